// ==== source/cnn_pkg.sv ====
// Shared constants, FSM state type and bus structs for the convolution engine, imported by every RTL module
package cnn_pkg;

  // ====================
  // Sizes
  // ====================
  localparam int ADDR_W         = 19;  // Byte address width
  localparam int DP_DEPTH       = 4;   // Dot product lanes and kernel edge
  localparam int MAX_DIM        = 32;  // Largest picture rows or columns
  localparam int DIM_W          = 6;   // Picture dimension field
  localparam int WORD_W         = 32;  // Memory data width
  localparam int BYTES_PER_WORD = 4;   // Result bytes per write word
  localparam int ACC_W          = 32;  // Accumulator width
  localparam int ACT_MAX        = 255; // Activation ceiling

  // ====================
  // Controller states
  // ====================
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    LOAD_WGT  = 3'd1,  // Four weight lines
    LOAD_BIAS = 3'd2,
    READ_LINE = 3'd3,  // One window line from the picture
    MAC       = 3'd4,
    WAIT_WR   = 3'd5,  // Writer still owns a word
    DONE      = 3'd6
  } cnn_state_e;

  // ====================
  // Buses
  // ====================
  typedef struct packed {
    logic [ADDR_W-1:0] addr_x;     // Picture
    logic [ADDR_W-1:0] addr_y;     // Weights
    logic [ADDR_W-1:0] addr_bias;
    logic [ADDR_W-1:0] addr_z;     // Result
    logic [DIM_W-1:0]  x_rows;
    logic [DIM_W-1:0]  x_cols;
  } cnn_cfg_t;

  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] addr;
  } rd_port_t;

  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] data;
  } wr_port_t;

  // One window sum from the MAC unit to the writer
  typedef struct packed {
    logic                    valid;
    logic                    last;   // Final window of the job
    logic signed [ACC_W-1:0] sum;
  } pix_t;

endpackage

// ==== source/cnn_ctrl.sv ====
// Job controller of the convolution engine, sequencing weight, bias and window line reads
`timescale 1ns/1ps

module cnn_ctrl
  import cnn_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  cnn_cfg_t          cfg,
  input  logic              go,
  output logic              done,
  output logic              busy,
  output rd_port_t          rd,
  input  logic              rd_ack,
  input  logic [WORD_W-1:0] rd_data,
  input  logic              wr_busy,
  output logic [WORD_W-1:0] line_data,
  output logic [1:0]        line_idx,
  output logic              line_strobe,
  output logic              wgt_strobe,
  output logic              bias_strobe,
  output logic              last_window,
  output logic              start
);

  cnn_state_e        state;
  logic              rd_req;
  logic [ADDR_W-1:0] rd_addr;
  logic [ADDR_W-1:0] next_addr;
  logic [ADDR_W-1:0] win_addr;   // Top left byte of the current window
  logic [DIM_W-1:0]  win_col;
  logic [DIM_W-1:0]  win_row;
  logic [DIM_W-1:0]  col_last;
  logic [DIM_W-1:0]  row_last;
  logic [1:0]        line_cnt;   // Weight line or window line
  logic              cap;        // Read data captured this cycle
  logic              can_req;
  logic              line3_hold; // Last line read waits for the writer

  assign col_last    = cfg.x_cols - DIM_W'(DP_DEPTH);
  assign row_last    = cfg.x_rows - DIM_W'(DP_DEPTH);
  assign last_window = (win_col == col_last) && (win_row == row_last);

  assign cap         = rd_req && rd_ack;
  assign line_data   = rd_data;
  assign line_idx    = line_cnt;
  assign line_strobe = cap && (state == READ_LINE);
  assign wgt_strobe  = cap && (state == LOAD_WGT);
  assign bias_strobe = cap && (state == LOAD_BIAS);
  assign start       = (state == IDLE) && go;

  assign rd.req  = rd_req;
  assign rd.addr = rd_addr;

  // ====================
  // Read address
  // ====================
  always_comb
  begin
    case (state)
      LOAD_WGT:  next_addr = cfg.addr_y + ADDR_W'({line_cnt, 2'b00});
      LOAD_BIAS: next_addr = cfg.addr_bias;
      default:   next_addr = win_addr + ADDR_W'(line_cnt) * ADDR_W'(cfg.x_cols);
    endcase
  end

  assign line3_hold = (line_cnt == 2'(DP_DEPTH - 1)) && wr_busy;
  assign can_req    = !rd_req && !rd_ack &&
                      ((state == LOAD_WGT) || (state == LOAD_BIAS) ||
                       ((state == READ_LINE) && !line3_hold));

  // ====================
  // Job FSM
  // ====================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      rd_req   <= 1'b0;
      rd_addr  <= '0;
      busy     <= 1'b0;
      done     <= 1'b0;
      line_cnt <= '0;
      win_col  <= '0;
      win_row  <= '0;
      win_addr <= '0;
    end
    else
    begin
      if (can_req)
      begin
        rd_req  <= 1'b1;
        rd_addr <= next_addr;
      end
      else if (cap)
        rd_req <= 1'b0;

      case (state)
        IDLE:
          if (go)
          begin
            state    <= LOAD_WGT;
            busy     <= 1'b1;
            line_cnt <= '0;
            win_col  <= '0;
            win_row  <= '0;
            win_addr <= cfg.addr_x;
          end
        LOAD_WGT:
          if (cap)
          begin
            line_cnt <= line_cnt + 2'd1;  // Wraps to line 0 for the picture
            if (line_cnt == 2'(DP_DEPTH - 1))
              state <= LOAD_BIAS;
          end
        LOAD_BIAS:
          if (cap)
            state <= READ_LINE;
        READ_LINE:
          if (cap)
            state <= MAC;
          else if (!rd_req && line3_hold)
            state <= WAIT_WR;
        MAC:
        begin
          line_cnt <= line_cnt + 2'd1;
          if (line_cnt != 2'(DP_DEPTH - 1))
            state <= READ_LINE;
          else if (last_window)
            state <= WAIT_WR;                 // Drain the final word
          else
          begin
            state <= READ_LINE;
            if (win_col == col_last)
            begin
              win_col  <= '0;
              win_row  <= win_row + DIM_W'(1);
              win_addr <= win_addr + ADDR_W'(DP_DEPTH);  // Next row, column 0
            end
            else
            begin
              win_col  <= win_col + DIM_W'(1);
              win_addr <= win_addr + ADDR_W'(1);
            end
          end
        end
        WAIT_WR:
          if (!wr_busy)
          begin
            // Line 0 here means the final window is complete
            if (line_cnt == 2'd0)
            begin
              state <= DONE;
              done  <= 1'b1;
            end
            else
              state <= READ_LINE;
          end
        DONE:
          if (!go)
          begin
            state <= IDLE;
            done  <= 1'b0;
            busy  <= 1'b0;
          end
        default:
          state <= IDLE;
      endcase
    end
  end

  // ====================
  // Checks
  // ====================
  a_rd_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (rd.req && !rd_ack) |=> $stable(rd.addr));

  a_dim_range: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> (cfg.x_rows <= DIM_W'(MAX_DIM)) && (cfg.x_cols <= DIM_W'(MAX_DIM)) &&
              (cfg.x_rows >= DIM_W'(DP_DEPTH)) && (cfg.x_cols >= DIM_W'(DP_DEPTH)));

endmodule

// ==== source/cnn_mac.sv ====
// Weight store and 4-lane signed dot product, accumulating one window sum for the writer
`timescale 1ns/1ps

module cnn_mac
  import cnn_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [WORD_W-1:0] line_data,
  input  logic [1:0]        line_idx,
  input  logic              line_strobe,
  input  logic              wgt_strobe,
  input  logic              bias_strobe,
  input  logic              last_window,
  output pix_t              pix
);

  logic signed [7:0]       wgt [DP_DEPTH][DP_DEPTH];  // [line][lane]
  logic signed [ACC_W-1:0] bias;
  logic signed [ACC_W-1:0] acc;
  logic signed [ACC_W-1:0] dot;
  logic                    valid_q;
  logic                    last_q;
  logic [1:0]              prev_idx;

  // ====================
  // Dot product
  // ====================
  always_comb
  begin
    dot = '0;
    for (int j = 0; j < DP_DEPTH; j++)
      dot = dot + ($signed({1'b0, line_data[8*j +: 8]}) * wgt[line_idx][j]);  // Pixel unsigned
  end

  always_ff @(posedge clk)
  begin
    if (wgt_strobe)
    begin
      for (int j = 0; j < DP_DEPTH; j++)
        wgt[line_idx][j] <= line_data[8*j +: 8];
    end
    if (bias_strobe)
      bias <= line_data;
    if (line_strobe)
      acc <= ((line_idx == 2'd0) ? bias : acc) + dot;  // Window starts from bias
  end

  // ====================
  // Result strobe
  // ====================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid_q  <= 1'b0;
      last_q   <= 1'b0;
      prev_idx <= 2'(DP_DEPTH - 1);
    end
    else
    begin
      valid_q <= line_strobe && (line_idx == 2'(DP_DEPTH - 1));
      last_q  <= line_strobe && (line_idx == 2'(DP_DEPTH - 1)) && last_window;
      if (line_strobe)
        prev_idx <= line_idx;
    end
  end

  assign pix.valid = valid_q;
  assign pix.last  = last_q;
  assign pix.sum   = acc;

  // Window lines arrive in order 0..3 and every window is complete
  a_line_order: assert property (@(posedge clk) disable iff (!rst_n)
    line_strobe |-> (line_idx == prev_idx + 2'd1));

endmodule

// ==== source/cnn_writer.sv ====
// Result writer of the convolution engine, with activation, byte packing and write handshake
`timescale 1ns/1ps

module cnn_writer
  import cnn_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ADDR_W-1:0] cfg_addr_z,
  input  logic              start,
  input  pix_t              pix,
  output wr_port_t          wr,
  input  logic              wr_ack,
  output logic              wr_busy
);

  logic [7:0]        act_byte;
  logic [WORD_W-1:0] shift_word;   // Newest byte at the top
  logic [WORD_W-1:0] shift_next;
  logic [WORD_W-1:0] word_out;
  logic [1:0]        byte_cnt;
  logic [1:0]        empty_bytes;
  logic              launch;
  logic              wr_req;
  logic              ack_wait;     // Req dropped, ack still high
  logic [ADDR_W-1:0] wr_addr;
  logic [WORD_W-1:0] wr_data;

  // ====================
  // Activation
  // ====================
  always_comb
  begin
    if ($signed(pix.sum) < 0)
      act_byte = 8'd0;
    else if ($signed(pix.sum) > $signed(ACC_W'(ACT_MAX)))
      act_byte = 8'(ACT_MAX);                          // Saturate
    else
      act_byte = pix.sum[7:0];
  end

  // ====================
  // Packing
  // ====================
  assign shift_next  = {act_byte, shift_word[WORD_W-1:8]};
  assign launch      = pix.valid && ((byte_cnt == 2'(BYTES_PER_WORD - 1)) || pix.last);
  assign empty_bytes = 2'(BYTES_PER_WORD - 1) - byte_cnt;
  assign word_out    = shift_next >> {empty_bytes, 3'b000};  // Zero fill on a short word

  always_ff @(posedge clk)
  begin
    if (pix.valid)
      shift_word <= shift_next;
    if (launch)
      wr_data <= word_out;
  end

  // ====================
  // Write handshake
  // ====================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      byte_cnt <= '0;
      wr_req   <= 1'b0;
      ack_wait <= 1'b0;
      wr_addr  <= '0;
    end
    else
    begin
      if (start)
        byte_cnt <= '0;
      else if (pix.valid)
        byte_cnt <= launch ? 2'd0 : byte_cnt + 2'd1;

      if (launch)
        wr_req <= 1'b1;
      else if (wr_req && wr_ack)
        wr_req <= 1'b0;

      if (wr_req && wr_ack)
        ack_wait <= 1'b1;
      else if (!wr_ack)
        ack_wait <= 1'b0;

      if (start)
        wr_addr <= cfg_addr_z;
      else if (wr_req && wr_ack)
        wr_addr <= wr_addr + ADDR_W'(BYTES_PER_WORD);  // Next word
    end
  end

  assign wr_busy = launch || wr_req || ack_wait;

  assign wr.req  = wr_req;
  assign wr.addr = wr_addr;
  assign wr.data = wr_data;

  // ====================
  // Checks
  // ====================
  a_wr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (wr.req && !wr_ack) |=> $stable(wr.data) && $stable(wr.addr));

  // Controller must hold the pixel while a word is still outstanding
  a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
    launch |-> !(wr_req || ack_wait));

endmodule

// ==== source/cnn_top.sv ====
// Top level of the 4x4 convolution engine, connecting the controller, MAC unit and result writer
`timescale 1ns/1ps

module cnn_top
  import cnn_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  // Software side
  input  cnn_cfg_t          cfg,
  input  logic              go,
  output logic              done,
  output logic              busy,

  // Read port
  output rd_port_t          rd,
  input  logic              rd_ack,
  input  logic [WORD_W-1:0] rd_data,

  // Write port
  output wr_port_t          wr,
  input  logic              wr_ack
);

  // ====================
  // Internal links
  // ====================
  logic [WORD_W-1:0] line_data;
  logic [1:0]        line_idx;
  logic              line_strobe;
  logic              wgt_strobe;
  logic              bias_strobe;
  logic              last_window;
  logic              start;     // IDLE exit pulse
  logic              wr_busy;
  pix_t              pix;

  cnn_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg         (cfg),
    .go          (go),
    .done        (done),
    .busy        (busy),
    .rd          (rd),
    .rd_ack      (rd_ack),
    .rd_data     (rd_data),
    .wr_busy     (wr_busy),
    .line_data   (line_data),
    .line_idx    (line_idx),
    .line_strobe (line_strobe),
    .wgt_strobe  (wgt_strobe),
    .bias_strobe (bias_strobe),
    .last_window (last_window),
    .start       (start)
  );

  cnn_mac u_mac (
    .clk         (clk),
    .rst_n       (rst_n),
    .line_data   (line_data),
    .line_idx    (line_idx),
    .line_strobe (line_strobe),
    .wgt_strobe  (wgt_strobe),
    .bias_strobe (bias_strobe),
    .last_window (last_window),
    .pix         (pix)
  );

  cnn_writer u_writer (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_addr_z (cfg.addr_z),
    .start      (start),
    .pix        (pix),
    .wr         (wr),
    .wr_ack     (wr_ack),
    .wr_busy    (wr_busy)
  );

endmodule

// ==== dv/cnn_mem_model.sv ====
// Byte-addressed memory for the convolution testbench, answering the read and write ports with four-phase handshakes
`timescale 1ns/1ps

module cnn_mem_model
  import cnn_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  rd_port_t          rd,
  output logic              rd_ack,
  output logic [WORD_W-1:0] rd_data,
  input  wr_port_t          wr,
  output logic              wr_ack,
  input  int unsigned       delay_max   // 0 gives an ack one cycle after req
);

  logic [7:0]  mem [2**ADDR_W];
  int unsigned rd_wait;
  int unsigned wr_wait;
  int unsigned rd_cnt;
  int unsigned wr_cnt;

  function automatic int unsigned pick_delay();
    return (delay_max == 0) ? 0 : $urandom_range(delay_max, 0);
  endfunction

  initial
  begin
    rd_ack  = 1'b0;
    wr_ack  = 1'b0;
    rd_data = '0;
    rd_wait = 0;
    wr_wait = 0;
    rd_cnt  = 0;
    wr_cnt  = 0;
  end

  // ====================
  // Port responses
  // ====================
  always @(posedge clk)
  begin
    #1;  // Outputs move just after the edge
    if (!rst_n)
    begin
      rd_ack = 1'b0;
      wr_ack = 1'b0;
    end
    else
    begin
      if (rd.req && !rd_ack)
      begin
        if (rd_cnt >= rd_wait)
        begin
          for (int b = 0; b < 4; b++)
            rd_data[8*b +: 8] = mem[rd.addr + b];  // Little-endian word
          rd_ack = 1'b1;
          rd_cnt = 0;
        end
        else
          rd_cnt++;
      end
      else if (!rd.req && rd_ack)
      begin
        rd_ack  = 1'b0;
        rd_wait = pick_delay();
      end

      if (wr.req && !wr_ack)
      begin
        if (wr_cnt >= wr_wait)
        begin
          for (int b = 0; b < 4; b++)
            mem[wr.addr + b] = wr.data[8*b +: 8];
          wr_ack = 1'b1;
          wr_cnt = 0;
        end
        else
          wr_cnt++;
      end
      else if (!wr.req && wr_ack)
      begin
        wr_ack  = 1'b0;
        wr_wait = pick_delay();
      end
    end
  end

endmodule

// ==== dv/cnn_tb.sv ====
// Testbench for the convolution engine, running directed jobs against a reference model of the window sums
`timescale 1ns/1ps

module cnn_tb
  import cnn_pkg::*;
();

  // Longest job is about 100 reads at up to 12 cycles each, ten times over with margin
  localparam int TIMEOUT_CYCLES = 200000;

  logic              clk;
  logic              rst_n;
  cnn_cfg_t          cfg;
  logic              go;
  logic              done;
  logic              busy;
  rd_port_t          rd;
  logic              rd_ack;
  logic [WORD_W-1:0] rd_data;
  wr_port_t          wr;
  logic              wr_ack;
  int unsigned       delay_max;
  int                cycles;
  logic              busy_seen;   // Busy observed during the last job

  cnn_top DUT (
    .clk(clk), .rst_n(rst_n), .cfg(cfg), .go(go), .done(done), .busy(busy),
    .rd(rd), .rd_ack(rd_ack), .rd_data(rd_data), .wr(wr), .wr_ack(wr_ack)
  );

  cnn_mem_model MEM (
    .clk(clk), .rst_n(rst_n), .rd(rd), .rd_ack(rd_ack), .rd_data(rd_data),
    .wr(wr), .wr_ack(wr_ack), .delay_max(delay_max)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Some tests failed");
      $fatal(1, "Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  // ====================
  // Helpers
  // ====================
  task automatic compare_value(string name, int expected, int actual);
    if (expected !== actual)
    begin
      $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "Check failed in %s", name);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [31:0] read_word(int a);
    return {MEM.mem[a+3], MEM.mem[a+2], MEM.mem[a+1], MEM.mem[a]};
  endfunction

  task automatic write_word(int a, logic [31:0] d);
    for (int b = 0; b < 4; b++)
      MEM.mem[a+b] = d[8*b +: 8];
  endtask

  function automatic logic [7:0] fill_byte(int a);
    return 8'(a ^ (a >> 8) ^ (a >> 16)) ^ 8'h3c;
  endfunction

  function automatic cnn_cfg_t make_cfg(int x, int y, int b, int z, int rows, int cols);
    cnn_cfg_t c;
    c.addr_x    = ADDR_W'(x);
    c.addr_y    = ADDR_W'(y);
    c.addr_bias = ADDR_W'(b);
    c.addr_z    = ADDR_W'(z);
    c.x_rows    = DIM_W'(rows);
    c.x_cols    = DIM_W'(cols);
    return c;
  endfunction

  task automatic load_random(cnn_cfg_t c, int wmax, int bmax);
    int v;
    for (int i = 0; i < int'(c.x_rows) * int'(c.x_cols); i++)
      MEM.mem[int'(c.addr_x) + i] = 8'($urandom_range(255, 0));
    for (int i = 0; i < 16; i++)
    begin
      v = int'($urandom_range(2 * wmax, 0)) - wmax;
      MEM.mem[int'(c.addr_y) + i] = 8'(v);
    end
    v = int'($urandom_range(2 * bmax, 0)) - bmax;
    write_word(int'(c.addr_bias), 32'(v));
  endtask

  // Window sum from bias, unsigned pixels and signed weights, then clamp to 0..255
  function automatic int expected_byte(cnn_cfg_t c, int idx);
    int ncol;
    int r;
    int col;
    int sum;
    int pa;
    ncol = int'(c.x_cols) - 3;
    r    = idx / ncol;
    col  = idx % ncol;
    sum  = int'($signed(read_word(int'(c.addr_bias))));
    for (int k = 0; k < 4; k++)
      for (int j = 0; j < 4; j++)
      begin
        pa  = int'(c.addr_x) + (r + k) * int'(c.x_cols) + col + j;
        sum = sum + int'(MEM.mem[pa]) * int'($signed(MEM.mem[int'(c.addr_y) + 4*k + j]));
      end
    if (sum < 0)
      return 0;
    return (sum > 255) ? 255 : sum;
  endfunction

  task automatic check_results(string name, cnn_cfg_t c);
    int count;
    int exp;
    count = (int'(c.x_rows) - 3) * (int'(c.x_cols) - 3);
    for (int i = 0; i < 4 * ((count + 3) / 4); i++)
    begin
      exp = (i < count) ? expected_byte(c, i) : 0;  // Tail of the last word is zero
      compare_value($sformatf("%s byte %0d", name, i), exp, int'(MEM.mem[int'(c.addr_z) + i]));
    end
  endtask

  // Four-phase go/done job, holding go for a while to see done stay up
  task automatic run_job(string name, cnn_cfg_t c);
    cfg       = c;
    go        = 1'b1;
    busy_seen = 1'b0;
    while (!done)
    begin
      next_cycle();
      if (busy)
        busy_seen = 1'b1;
    end
    repeat (3)
    begin
      next_cycle();
      compare_value({name, " done held while go high"}, 1, int'(done));
    end
    go = 1'b0;
    while (done)
      next_cycle();
    compare_value({name, " busy after done"}, 0, int'(busy));
    next_cycle();
  endtask

  // ====================
  // Directed tests
  // ====================
  task automatic single_window();
    cnn_cfg_t c;
    c = make_cfg('h1000, 'h0100, 'h0200, 'h2000, 4, 4);
    for (int i = 0; i < 16; i++)
    begin
      MEM.mem['h1000 + i] = 8'(i);
      MEM.mem['h0100 + i] = 8'd1;
    end
    write_word('h0200, 32'd5);
    run_job("single_window", c);
    compare_value("single_window word", 125, int'(read_word('h2000)));  // 0+..+15 plus 5
  endtask

  task automatic random_8x8();
    cnn_cfg_t c;
    c = make_cfg('h1000, 'h0100, 'h0200, 'h2000, 8, 8);
    load_random(c, 3, 200);
    run_job("random_8x8", c);
    check_results("random_8x8", c);
  endtask

  task automatic saturation_clamp();
    cnn_cfg_t c;
    c = make_cfg('h1000, 'h0100, 'h0200, 'h2000, 4, 6);
    for (int i = 0; i < 24; i++)
      MEM.mem['h1000 + i] = ((i % 6) >= 3) ? 8'd255 : 8'd0;  // Bright right half
    for (int i = 0; i < 16; i++)
      MEM.mem['h0100 + i] = 8'd127;
    write_word('h0200, 32'(-200000));
    run_job("saturation_clamp", c);
    compare_value("saturation_clamp word", 32'h00ffff00, int'(read_word('h2000)));
    check_results("saturation_clamp", c);
  endtask

  task automatic small_5x6();
    cnn_cfg_t c;
    c = make_cfg('h1000, 'h0100, 'h0200, 'h3000, 5, 6);
    load_random(c, 3, 200);
    for (int a = 'h3000; a < 'h3000 + 72; a++)
      MEM.mem[a] = fill_byte(a);
    run_job("small_5x6", c);
    check_results("small_5x6", c);
    for (int a = 'h3000 + 8; a < 'h3000 + 72; a++)
      compare_value($sformatf("small_5x6 untouched %0h", a), int'(fill_byte(a)),
                    int'(MEM.mem[a]));
    compare_value("small_5x6 busy seen", 1, int'(busy_seen));
  endtask

  task automatic back_pressure();
    cnn_cfg_t ca;
    cnn_cfg_t cb;
    ca = make_cfg('h1000, 'h0100, 'h0200, 'h2400, 8, 8);
    cb = make_cfg('h1800, 'h0300, 'h0310, 'h2800, 7, 9);
    load_random(ca, 3, 200);
    load_random(cb, 3, 200);
    delay_max = 8;
    run_job("back_pressure job a", ca);
    run_job("back_pressure job b", cb);
    check_results("back_pressure job a", ca);
    check_results("back_pressure job b", cb);
  endtask

  // ====================
  // Main sequence
  // ====================
  initial
  begin
    cfg       = '0;
    go        = 1'b0;
    delay_max = 0;
    cycles    = 0;
    busy_seen = 1'b0;
    rst_n     = 1'b0;
    void'($urandom(32'h658f0cf9));
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();
    single_window();
    random_8x8();
    saturation_clamp();
    small_5x6();
    back_pressure();
    $display("All tests passed");
    $finish;
  end

endmodule

// ==== cnn_top.f ====
source/cnn_pkg.sv
source/cnn_ctrl.sv
source/cnn_mac.sv
source/cnn_writer.sv
source/cnn_top.sv
dv/cnn_mem_model.sv
dv/cnn_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the convolution engine testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f cnn_top.f \
  --top-module cnn_tb \
  -o cnn_sim

./obj_dir/cnn_sim
